/* files.f */
pixel_cluster_pkg.sv
pixel_cluster_color_match.sv
pixel_cluster_scan.sv
pixel_cluster_csr.sv
pixel_cluster_clusterer.sv
pixel_cluster_done_irq.sv
pixel_cluster_top.sv
tb_clock.sv
tb_pixel_cluster.sv

/* pixel_cluster_clusterer.sv */
module pixel_cluster_clusterer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  pixel_cluster_pkg::coord_t pixel_x,
    input  pixel_cluster_pkg::coord_t pixel_y,
    input  logic                      valid,
    input  pixel_cluster_pkg::coord_t range,
    output pixel_cluster_pkg::coord_t slot_center_x [pixel_cluster_pkg::N_CLUSTERS],
    output pixel_cluster_pkg::coord_t slot_center_y [pixel_cluster_pkg::N_CLUSTERS],
    output pixel_cluster_pkg::coord_t slot_min_x [pixel_cluster_pkg::N_CLUSTERS],
    output pixel_cluster_pkg::coord_t slot_min_y [pixel_cluster_pkg::N_CLUSTERS],
    output pixel_cluster_pkg::coord_t slot_max_x [pixel_cluster_pkg::N_CLUSTERS],
    output pixel_cluster_pkg::coord_t slot_max_y [pixel_cluster_pkg::N_CLUSTERS],
    output pixel_cluster_pkg::count_t slot_count [pixel_cluster_pkg::N_CLUSTERS]
);

    // Pixel in flight at each stage
    pixel_cluster_pkg::calc_coord_t pipe_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t pipe_y [pixel_cluster_pkg::N_CLUSTERS];
    logic [pixel_cluster_pkg::N_CLUSTERS-1:0] pipe_valid;

    // Slot state
    pixel_cluster_pkg::calc_coord_t cen_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t cen_y [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t min_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t min_y [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t max_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t max_y [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::count_t      count [pixel_cluster_pkg::N_CLUSTERS];

    pixel_cluster_pkg::calc_coord_t diff_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::calc_coord_t diff_y [pixel_cluster_pkg::N_CLUSTERS];
    logic [pixel_cluster_pkg::CALC_BITS:0]     sum_x [pixel_cluster_pkg::N_CLUSTERS];
    logic [pixel_cluster_pkg::CALC_BITS:0]     sum_y [pixel_cluster_pkg::N_CLUSTERS];
    logic [2*pixel_cluster_pkg::CALC_BITS:0]   dist_sq [pixel_cluster_pkg::N_CLUSTERS];
    logic [2*$bits(pixel_cluster_pkg::coord_t)-1:0] range_sq;
    logic [pixel_cluster_pkg::N_CLUSTERS-1:0] hit;

    always_ff @(posedge clk) begin
        range_sq <= range * range;
    end

    // Distance against the live slot centre, so it stays in the same cycle
    always_comb begin
        for (int i = 0; i < pixel_cluster_pkg::N_CLUSTERS; i++) begin
            diff_x[i]  = (cen_x[i] > pipe_x[i]) ? cen_x[i] - pipe_x[i] : pipe_x[i] - cen_x[i];
            diff_y[i]  = (cen_y[i] > pipe_y[i]) ? cen_y[i] - pipe_y[i] : pipe_y[i] - cen_y[i];
            dist_sq[i] = diff_x[i] * diff_x[i] + diff_y[i] * diff_y[i];
            sum_x[i]   = {1'b0, cen_x[i]} + {1'b0, pipe_x[i]};
            sum_y[i]   = {1'b0, cen_y[i]} + {1'b0, pipe_y[i]};
            hit[i]     = pipe_valid[i] && (count[i] == '0 || dist_sq[i] <= range_sq);
        end
    end

    always_ff @(posedge clk) begin
        pipe_x[0] <= pixel_x[pixel_cluster_pkg::CALC_BITS-1:0];
        pipe_y[0] <= pixel_y[pixel_cluster_pkg::CALC_BITS-1:0];
        for (int i = 1; i < pixel_cluster_pkg::N_CLUSTERS; i++) begin
            pipe_x[i] <= pipe_x[i-1];
            pipe_y[i] <= pipe_y[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pipe_valid <= '0;
            for (int i = 0; i < pixel_cluster_pkg::N_CLUSTERS; i++) begin
                cen_x[i] <= '0;
                cen_y[i] <= '0;
                min_x[i] <= '0;
                min_y[i] <= '0;
                max_x[i] <= '0;
                max_y[i] <= '0;
                count[i] <= '0;
            end
        end else begin
            pipe_valid[0] <= valid;
            // An absorbed pixel goes no further
            for (int i = 1; i < pixel_cluster_pkg::N_CLUSTERS; i++) begin
                pipe_valid[i] <= pipe_valid[i-1] && !hit[i-1];
            end
            for (int i = 0; i < pixel_cluster_pkg::N_CLUSTERS; i++) begin
                if (hit[i]) begin
                    if (count[i] == '0) begin
                        cen_x[i] <= pipe_x[i];
                        cen_y[i] <= pipe_y[i];
                        min_x[i] <= pipe_x[i];
                        min_y[i] <= pipe_y[i];
                        max_x[i] <= pipe_x[i];
                        max_y[i] <= pipe_y[i];
                    end else begin
                        cen_x[i] <= sum_x[i][pixel_cluster_pkg::CALC_BITS:1];
                        cen_y[i] <= sum_y[i][pixel_cluster_pkg::CALC_BITS:1];
                        min_x[i] <= (pipe_x[i] < min_x[i]) ? pipe_x[i] : min_x[i];
                        min_y[i] <= (pipe_y[i] < min_y[i]) ? pipe_y[i] : min_y[i];
                        max_x[i] <= (pipe_x[i] > max_x[i]) ? pipe_x[i] : max_x[i];
                        max_y[i] <= (pipe_y[i] > max_y[i]) ? pipe_y[i] : max_y[i];
                    end
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    // Zero padded to the register coordinate width
    always_comb begin
        for (int i = 0; i < pixel_cluster_pkg::N_CLUSTERS; i++) begin
            slot_center_x[i] = pixel_cluster_pkg::coord_t'(cen_x[i]);
            slot_center_y[i] = pixel_cluster_pkg::coord_t'(cen_y[i]);
            slot_min_x[i]    = pixel_cluster_pkg::coord_t'(min_x[i]);
            slot_min_y[i]    = pixel_cluster_pkg::coord_t'(min_y[i]);
            slot_max_x[i]    = pixel_cluster_pkg::coord_t'(max_x[i]);
            slot_max_y[i]    = pixel_cluster_pkg::coord_t'(max_y[i]);
            slot_count[i]    = count[i];
        end
    end

    for (genvar g = 0; g < pixel_cluster_pkg::N_CLUSTERS; g++) begin : g_box_check
        a_box_order: assert property (@(posedge clk) disable iff (reset)
            count[g] != '0 |-> (min_x[g] <= max_x[g] && min_y[g] <= max_y[g]));
    end

endmodule

/* pixel_cluster_color_match.sv */
module pixel_cluster_color_match (
    input  pixel_cluster_pkg::pixel_t pixel,
    input  logic                      pixel_valid,
    input  pixel_cluster_pkg::pixel_t threshold,
    input  logic [2:0]                enable,
    input  logic [2:0]                less_than,
    output logic                      match
);

    pixel_cluster_pkg::color_t channel [pixel_cluster_pkg::N_COLORS];
    pixel_cluster_pkg::color_t level [pixel_cluster_pkg::N_COLORS];
    logic [pixel_cluster_pkg::N_COLORS-1:0] pass;

    always_comb begin
        for (int i = 0; i < pixel_cluster_pkg::N_COLORS; i++) begin
            channel[i] = pixel[i*pixel_cluster_pkg::COLOR_BITS +: pixel_cluster_pkg::COLOR_BITS];
            level[i]   = threshold[i*pixel_cluster_pkg::COLOR_BITS +:
                                   pixel_cluster_pkg::COLOR_BITS];
            // Less-than set means below threshold, clear means at or above
            pass[i] = !enable[i] || ((channel[i] < level[i]) == less_than[i]);
        end
    end

    assign match = pixel_valid && (&pass);

endmodule

/* pixel_cluster_csr.sv */
module pixel_cluster_csr (
    input  logic                        clk,
    input  logic                        reset,
    input  pixel_cluster_pkg::addr_t    mm_address,
    input  pixel_cluster_pkg::byte_en_t mm_byteenable,
    input  logic                        mm_read,
    input  logic                        mm_write,
    input  pixel_cluster_pkg::reg_t     mm_writedata,
    output pixel_cluster_pkg::reg_t     mm_readdata,
    output pixel_cluster_pkg::pixel_t   cmp_threshold_0,
    output pixel_cluster_pkg::pixel_t   cmp_threshold_1,
    output logic [2:0]                  cmp_enable_0,
    output logic [2:0]                  cmp_enable_1,
    output logic [2:0]                  cmp_less_0,
    output logic [2:0]                  cmp_less_1,
    output pixel_cluster_pkg::coord_t   range,
    output logic                        control_write,
    input  pixel_cluster_pkg::coord_t   slot_center_x [pixel_cluster_pkg::N_CLUSTERS],
    input  pixel_cluster_pkg::coord_t   slot_center_y [pixel_cluster_pkg::N_CLUSTERS],
    input  pixel_cluster_pkg::coord_t   slot_min_x [pixel_cluster_pkg::N_CLUSTERS],
    input  pixel_cluster_pkg::coord_t   slot_min_y [pixel_cluster_pkg::N_CLUSTERS],
    input  pixel_cluster_pkg::coord_t   slot_max_x [pixel_cluster_pkg::N_CLUSTERS],
    input  pixel_cluster_pkg::coord_t   slot_max_y [pixel_cluster_pkg::N_CLUSTERS],
    input  pixel_cluster_pkg::count_t   slot_count [pixel_cluster_pkg::N_CLUSTERS]
);

    pixel_cluster_pkg::reg_t compare_0;
    pixel_cluster_pkg::reg_t compare_1;
    pixel_cluster_pkg::reg_t range_reg;
    pixel_cluster_pkg::reg_t read_map [pixel_cluster_pkg::N_REGS];
    pixel_cluster_pkg::reg_t read_word;
    pixel_cluster_pkg::reg_t read_mask;

    // Byte-enabled writes, control only produces the pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            compare_0     <= '0;
            compare_1     <= '0;
            range_reg     <= '0;
            control_write <= 1'b0;
        end else begin
            control_write <= mm_write && (mm_address == pixel_cluster_pkg::REG_CONTROL);
            if (mm_write) begin
                for (int i = 0; i < $bits(pixel_cluster_pkg::byte_en_t); i++) begin
                    if (mm_byteenable[i]) begin
                        case (mm_address)
                            pixel_cluster_pkg::REG_COMPARE_0:
                                compare_0[i*8 +: 8] <= mm_writedata[i*8 +: 8];
                            pixel_cluster_pkg::REG_COMPARE_1:
                                compare_1[i*8 +: 8] <= mm_writedata[i*8 +: 8];
                            pixel_cluster_pkg::REG_RANGE:
                                range_reg[i*8 +: 8] <= mm_writedata[i*8 +: 8];
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    // Read map, slot k starts at REG_SLOT_BASE + 4k
    always_comb begin
        int base;
        read_map[pixel_cluster_pkg::REG_CONTROL]   = '0;
        read_map[pixel_cluster_pkg::REG_COMPARE_0] = compare_0;
        read_map[pixel_cluster_pkg::REG_COMPARE_1] = compare_1;
        read_map[pixel_cluster_pkg::REG_RANGE]     = range_reg;
        for (int k = 0; k < pixel_cluster_pkg::N_CLUSTERS; k++) begin
            base = pixel_cluster_pkg::REG_SLOT_BASE + k * pixel_cluster_pkg::REGS_PER_SLOT;
            read_map[base]     = {slot_center_y[k], slot_center_x[k]};
            read_map[base + 1] = {slot_min_y[k], slot_min_x[k]};
            read_map[base + 2] = {slot_max_y[k], slot_max_x[k]};
            read_map[base + 3] = pixel_cluster_pkg::reg_t'(slot_count[k]);
        end
    end

    always_comb begin
        read_word = (mm_address < pixel_cluster_pkg::N_REGS) ? read_map[mm_address] : '0;
        for (int i = 0; i < $bits(pixel_cluster_pkg::byte_en_t); i++) begin
            read_mask[i*8 +: 8] = {8{mm_byteenable[i]}};
        end
    end

    // Write wins over a simultaneous read
    always_ff @(posedge clk) begin
        if (mm_read && !mm_write) begin
            mm_readdata <= read_word & read_mask;
        end
    end

    // Field decode
    assign cmp_threshold_0 = compare_0[$bits(pixel_cluster_pkg::pixel_t)-1:0];
    assign cmp_threshold_1 = compare_1[$bits(pixel_cluster_pkg::pixel_t)-1:0];
    assign cmp_enable_0    = compare_0[pixel_cluster_pkg::CMP_ENABLE_LSB +: 3];
    assign cmp_enable_1    = compare_1[pixel_cluster_pkg::CMP_ENABLE_LSB +: 3];
    assign cmp_less_0      = compare_0[pixel_cluster_pkg::CMP_LESS_LSB +: 3];
    assign cmp_less_1      = compare_1[pixel_cluster_pkg::CMP_LESS_LSB +: 3];
    assign range           = range_reg[$bits(pixel_cluster_pkg::coord_t)-1:0];

    a_control_pulse: assert property (
        @(posedge clk) disable iff (reset) control_write |=> !control_write);

endmodule

/* pixel_cluster_done_irq.sv */
module pixel_cluster_done_irq (
    input  logic clk,
    input  logic reset,
    input  logic frame_end,
    input  logic clear,
    output logic irq
);

    // The sticky flag is the last of the IRQ_DELAY stages
    logic [pixel_cluster_pkg::IRQ_DELAY-2:0] delay_pipe;

    always_ff @(posedge clk) begin
        if (reset) begin
            delay_pipe <= '0;
        end else begin
            delay_pipe <= {delay_pipe[pixel_cluster_pkg::IRQ_DELAY-3:0], frame_end};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            irq <= 1'b0;
        end else if (delay_pipe[pixel_cluster_pkg::IRQ_DELAY-2]) begin
            irq <= 1'b1;
        end
    end

endmodule

/* pixel_cluster_pkg.sv */
package pixel_cluster_pkg;

    // Register port words
    typedef logic [31:0] reg_t;
    typedef logic [4:0]  addr_t;
    typedef logic [3:0]  byte_en_t;

    // Pixel format, blue in the low byte and red in the high byte
    localparam int N_COLORS   = 3;
    localparam int COLOR_BITS = 8;

    typedef logic [COLOR_BITS-1:0]          color_t;
    typedef logic [N_COLORS*COLOR_BITS-1:0] pixel_t;

    // Frame geometry
    localparam int FRAME_WIDTH  = 32;
    localparam int FRAME_HEIGHT = 24;
    localparam int MAX_DIM      = (FRAME_WIDTH > FRAME_HEIGHT) ? FRAME_WIDTH : FRAME_HEIGHT;

    // Internal width covers the larger dimension inclusive
    localparam int CALC_BITS = $clog2(MAX_DIM + 1);

    typedef logic [15:0]          coord_t;
    typedef logic [CALC_BITS-1:0] calc_coord_t;
    typedef logic [15:0]          count_t;

    // Cluster slots and the frame-done delay that follows their pipeline
    localparam int N_CLUSTERS = 4;
    localparam int IRQ_DELAY  = N_CLUSTERS + 4;

    // Register map
    localparam addr_t REG_CONTROL   = 5'd0;
    localparam addr_t REG_COMPARE_0 = 5'd1;
    localparam addr_t REG_COMPARE_1 = 5'd2;
    localparam addr_t REG_RANGE     = 5'd3;

    localparam int REG_SLOT_BASE = 4;
    localparam int REGS_PER_SLOT = 4;
    localparam int N_REGS        = REG_SLOT_BASE + N_CLUSTERS * REGS_PER_SLOT;

    // Compare register fields above the three thresholds
    localparam int CMP_ENABLE_LSB = 24;
    localparam int CMP_LESS_LSB   = 27;

endpackage

/* pixel_cluster_scan.sv */
module pixel_cluster_scan (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      st_ready,
    input  logic                      st_startofpacket,
    input  logic                      st_endofpacket,
    input  logic                      st_valid,
    input  pixel_cluster_pkg::pixel_t st_data,
    output pixel_cluster_pkg::pixel_t pixel,
    output logic                      pixel_valid,
    output pixel_cluster_pkg::coord_t pixel_x,
    output pixel_cluster_pkg::coord_t pixel_y,
    output logic                      pixel_end
);

    logic done;
    logic last_col;

    assign last_col = (pixel_x == pixel_cluster_pkg::coord_t'(pixel_cluster_pkg::FRAME_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (st_valid) begin
            pixel <= st_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st_ready    <= 1'b0;
            pixel_valid <= 1'b0;
            pixel_x     <= '0;
            pixel_y     <= '0;
            pixel_end   <= 1'b0;
            done        <= 1'b0;
        end else begin
            st_ready  <= 1'b1;
            pixel_end <= 1'b0;
            if (st_valid) begin
                if (st_startofpacket) begin
                    pixel_x     <= '0;
                    pixel_y     <= '0;
                    pixel_valid <= 1'b1;
                    done        <= 1'b0;
                end else begin
                    // Row major order
                    pixel_x <= last_col ? '0 : pixel_x + 1'b1;
                    pixel_y <= last_col ? pixel_y + 1'b1 : pixel_y;
                    done    <= st_endofpacket;
                end
            end
            // One cycle after the last pixel
            if (done) begin
                pixel_x     <= '0;
                pixel_y     <= '0;
                pixel_valid <= 1'b0;
                pixel_end   <= 1'b1;
                done        <= 1'b0;
            end
        end
    end

    a_x_in_frame: assert property (@(posedge clk) disable iff (reset)
        pixel_valid |-> (pixel_x < pixel_cluster_pkg::FRAME_WIDTH &&
                         pixel_y < pixel_cluster_pkg::FRAME_HEIGHT));

endmodule

/* pixel_cluster_top.sv */
module pixel_cluster_top (
    input  logic                        clk,
    input  logic                        reset,
    input  pixel_cluster_pkg::addr_t    mm_address,
    input  pixel_cluster_pkg::byte_en_t mm_byteenable,
    input  logic                        mm_read,
    input  logic                        mm_write,
    input  pixel_cluster_pkg::reg_t     mm_writedata,
    output pixel_cluster_pkg::reg_t     mm_readdata,
    output logic                        st_ready,
    input  logic                        st_startofpacket,
    input  logic                        st_endofpacket,
    input  logic                        st_valid,
    input  pixel_cluster_pkg::pixel_t   st_data,
    output logic                        irq
);

    pixel_cluster_pkg::pixel_t cmp_threshold_0, cmp_threshold_1;
    logic [2:0]                cmp_enable_0, cmp_enable_1;
    logic [2:0]                cmp_less_0, cmp_less_1;
    pixel_cluster_pkg::coord_t range;
    logic                      control_write;

    pixel_cluster_pkg::pixel_t pixel;
    logic                      pixel_valid;
    pixel_cluster_pkg::coord_t pixel_x, pixel_y;
    logic                      pixel_end;
    logic                      match_0, match_1;

    pixel_cluster_pkg::coord_t slot_center_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::coord_t slot_center_y [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::coord_t slot_min_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::coord_t slot_min_y [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::coord_t slot_max_x [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::coord_t slot_max_y [pixel_cluster_pkg::N_CLUSTERS];
    pixel_cluster_pkg::count_t slot_count [pixel_cluster_pkg::N_CLUSTERS];

    // Decode
    pixel_cluster_csr u_csr (.*);
    pixel_cluster_scan u_scan (.*);

    // Execute, a pixel must pass both rules
    pixel_cluster_color_match u_match_0 (
        .pixel(pixel), .pixel_valid(pixel_valid), .threshold(cmp_threshold_0),
        .enable(cmp_enable_0), .less_than(cmp_less_0), .match(match_0));
    pixel_cluster_color_match u_match_1 (
        .pixel(pixel), .pixel_valid(pixel_valid), .threshold(cmp_threshold_1),
        .enable(cmp_enable_1), .less_than(cmp_less_1), .match(match_1));

    pixel_cluster_clusterer u_clusterer (
        .clear(control_write), .valid(match_0 && match_1), .*);

    // Result
    pixel_cluster_done_irq u_done_irq (
        .clk(clk), .reset(reset), .frame_end(pixel_end), .clear(control_write), .irq(irq));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the pixel cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f files.f --top-module tb_pixel_cluster -o tb_pixel_cluster
./obj_dir/tb_pixel_cluster > sim.log
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #20 clk = ~clk;
    end

    // Reset spans two rising edges
    initial begin
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

/* tb_pixel_cluster.sv */
module tb_pixel_cluster;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int FRAME_PIXELS = pixel_cluster_pkg::FRAME_WIDTH *
                                  pixel_cluster_pkg::FRAME_HEIGHT;
    localparam int N_FRAMES     = 12;
    // Margin covers register traffic between frames
    localparam int WATCHDOG_NS  = N_FRAMES * FRAME_PIXELS * CLK_PERIOD + 200_000;
    localparam int IRQ_LATENCY  = pixel_cluster_pkg::IRQ_DELAY + 1;

    logic                        clk;
    logic                        reset;
    pixel_cluster_pkg::addr_t    mm_address;
    pixel_cluster_pkg::byte_en_t mm_byteenable;
    logic                        mm_read;
    logic                        mm_write;
    pixel_cluster_pkg::reg_t     mm_writedata;
    pixel_cluster_pkg::reg_t     mm_readdata;
    logic                        st_ready;
    logic                        st_startofpacket;
    logic                        st_endofpacket;
    logic                        st_valid;
    pixel_cluster_pkg::pixel_t   st_data;
    logic                        irq;

    integer seed = 32'h36e3_2e0b;
    integer r;
    int errors;
    int test_errors;
    int test_num;
    logic irq_after_reset;
    pixel_cluster_pkg::reg_t got;
    pixel_cluster_pkg::reg_t data;
    pixel_cluster_pkg::addr_t addr;
    pixel_cluster_pkg::byte_en_t be;

    // Reference model of the writable registers and the slots
    pixel_cluster_pkg::reg_t m_regs [4];
    int m_cx [pixel_cluster_pkg::N_CLUSTERS];
    int m_cy [pixel_cluster_pkg::N_CLUSTERS];
    int m_minx [pixel_cluster_pkg::N_CLUSTERS];
    int m_miny [pixel_cluster_pkg::N_CLUSTERS];
    int m_maxx [pixel_cluster_pkg::N_CLUSTERS];
    int m_maxy [pixel_cluster_pkg::N_CLUSTERS];
    int m_count [pixel_cluster_pkg::N_CLUSTERS];

    tb_clock u_clock (.clk(clk), .reset(reset));

    pixel_cluster_top UUT (.*);

    function automatic pixel_cluster_pkg::reg_t byte_mask(pixel_cluster_pkg::byte_en_t mask);
        pixel_cluster_pkg::reg_t m;
        for (int b = 0; b < 4; b++) begin
            m[b*8 +: 8] = mask[b] ? 8'hFF : 8'h00;
        end
        return m;
    endfunction

    function automatic void model_clear();
        for (int k = 0; k < pixel_cluster_pkg::N_CLUSTERS; k++) begin
            m_cx[k]    = 0;
            m_cy[k]    = 0;
            m_minx[k]  = 0;
            m_miny[k]  = 0;
            m_maxx[k]  = 0;
            m_maxy[k]  = 0;
            m_count[k] = 0;
        end
    endfunction

    // Disabled channels pass and enabled ones test below or at/above threshold
    function automatic logic rule_pass(pixel_cluster_pkg::reg_t rule,
                                       pixel_cluster_pkg::pixel_t p);
        int ch;
        int thr;
        for (int c = 0; c < pixel_cluster_pkg::N_COLORS; c++) begin
            ch  = p[c*pixel_cluster_pkg::COLOR_BITS +: pixel_cluster_pkg::COLOR_BITS];
            thr = rule[c*pixel_cluster_pkg::COLOR_BITS +: pixel_cluster_pkg::COLOR_BITS];
            if (rule[pixel_cluster_pkg::CMP_ENABLE_LSB + c]) begin
                if (rule[pixel_cluster_pkg::CMP_LESS_LSB + c] && ch >= thr) return 1'b0;
                if (!rule[pixel_cluster_pkg::CMP_LESS_LSB + c] && ch < thr) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // First slot that is empty or close enough takes the pixel
    function automatic void model_cluster(int x, int y);
        int dx;
        int dy;
        longint rng;
        rng = m_regs[pixel_cluster_pkg::REG_RANGE][15:0];
        for (int k = 0; k < pixel_cluster_pkg::N_CLUSTERS; k++) begin
            dx = (m_cx[k] > x) ? m_cx[k] - x : x - m_cx[k];
            dy = (m_cy[k] > y) ? m_cy[k] - y : y - m_cy[k];
            if (m_count[k] == 0 || longint'(dx * dx + dy * dy) <= rng * rng) begin
                if (m_count[k] == 0) begin
                    m_cx[k]   = x;
                    m_cy[k]   = y;
                    m_minx[k] = x;
                    m_miny[k] = y;
                    m_maxx[k] = x;
                    m_maxy[k] = y;
                end else begin
                    m_cx[k]   = (m_cx[k] + x) / 2;
                    m_cy[k]   = (m_cy[k] + y) / 2;
                    m_minx[k] = (x < m_minx[k]) ? x : m_minx[k];
                    m_miny[k] = (y < m_miny[k]) ? y : m_miny[k];
                    m_maxx[k] = (x > m_maxx[k]) ? x : m_maxx[k];
                    m_maxy[k] = (y > m_maxy[k]) ? y : m_maxy[k];
                end
                m_count[k]++;
                return;
            end
        end
    endfunction

    task automatic check_reg(string name, pixel_cluster_pkg::reg_t expected,
                             pixel_cluster_pkg::reg_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_irq(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_ready(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic bus_write(pixel_cluster_pkg::addr_t a, pixel_cluster_pkg::reg_t d,
                             pixel_cluster_pkg::byte_en_t mask);
        @(posedge clk);
        #2;
        mm_address    = a;
        mm_writedata  = d;
        mm_byteenable = mask;
        mm_write      = 1'b1;
        @(posedge clk);
        #2;
        mm_write = 1'b0;
    endtask

    task automatic bus_read(pixel_cluster_pkg::addr_t a, pixel_cluster_pkg::byte_en_t mask,
                            output pixel_cluster_pkg::reg_t d);
        @(posedge clk);
        #2;
        mm_address    = a;
        mm_byteenable = mask;
        mm_read       = 1'b1;
        @(posedge clk);
        #2;
        mm_read = 1'b0;
        d = mm_readdata;
    endtask

    // Bus write plus the same update in the model
    task automatic write_reg(pixel_cluster_pkg::addr_t a, pixel_cluster_pkg::reg_t d,
                             pixel_cluster_pkg::byte_en_t mask);
        bus_write(a, d, mask);
        if (a == pixel_cluster_pkg::REG_CONTROL) begin
            model_clear();
        end else begin
            m_regs[a] = (m_regs[a] & ~byte_mask(mask)) | (d & byte_mask(mask));
        end
    endtask

    task automatic clear_slots();
        write_reg(pixel_cluster_pkg::REG_CONTROL, 32'h0000_0001, 4'hF);
        wait_cycles(1);
        check_irq("irq", 1'b0, irq);
    endtask

    // Sparse frames set red at or above 0x80 on about one pixel in 32
    task automatic send_frame(logic sparse);
        integer v;
        pixel_cluster_pkg::pixel_t p;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            v = $random(seed);
            p = v[23:0];
            if (sparse) begin
                p[23] = (v[28:24] == 5'd0);
            end
            @(posedge clk);
            #2;
            st_valid         = 1'b1;
            st_startofpacket = (i == 0);
            st_endofpacket   = (i == FRAME_PIXELS - 1);
            st_data          = p;
            if (rule_pass(m_regs[1], p) && rule_pass(m_regs[2], p)) begin
                model_cluster(i % pixel_cluster_pkg::FRAME_WIDTH,
                              i / pixel_cluster_pkg::FRAME_WIDTH);
            end
        end
        @(posedge clk);
        #2;
        st_valid         = 1'b0;
        st_startofpacket = 1'b0;
        st_endofpacket   = 1'b0;
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < IRQ_LATENCY + 4) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (irq !== 1'b1) begin
            $display("irq did not rise within %0d cycles of the frame end", cycles);
            test_errors++;
        end else if (cycles != IRQ_LATENCY) begin
            $display("irq rose %0d cycles after the frame end instead of %0d",
                     cycles, IRQ_LATENCY);
            test_errors++;
        end
    endtask

    task automatic check_slots();
        pixel_cluster_pkg::reg_t rd;
        int base;
        for (int k = 0; k < pixel_cluster_pkg::N_CLUSTERS; k++) begin
            base = pixel_cluster_pkg::REG_SLOT_BASE + k * pixel_cluster_pkg::REGS_PER_SLOT;
            bus_read(pixel_cluster_pkg::addr_t'(base), 4'hF, rd);
            check_reg($sformatf("slot%0d_center", k), {16'(m_cy[k]), 16'(m_cx[k])}, rd);
            bus_read(pixel_cluster_pkg::addr_t'(base + 1), 4'hF, rd);
            check_reg($sformatf("slot%0d_min", k), {16'(m_miny[k]), 16'(m_minx[k])}, rd);
            bus_read(pixel_cluster_pkg::addr_t'(base + 2), 4'hF, rd);
            check_reg($sformatf("slot%0d_max", k), {16'(m_maxy[k]), 16'(m_maxx[k])}, rd);
            bus_read(pixel_cluster_pkg::addr_t'(base + 3), 4'hF, rd);
            check_reg($sformatf("slot%0d_count", k), 32'(m_count[k]), rd);
        end
    endtask

    task automatic end_test(string name);
        if (test_errors == 0) begin
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_num, name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
        test_num++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        mm_address       = '0;
        mm_byteenable    = '0;
        mm_read          = 1'b0;
        mm_write         = 1'b0;
        mm_writedata     = '0;
        st_startofpacket = 1'b0;
        st_endofpacket   = 1'b0;
        st_valid         = 1'b0;
        st_data          = '0;
        errors           = 0;
        test_errors      = 0;
        test_num         = 1;
        for (int i = 0; i < 4; i++) begin
            m_regs[i] = '0;
        end
        model_clear();
        @(negedge reset);
        irq_after_reset = irq;
        check_ready("st_ready", 1'b0, st_ready);
        wait_cycles(1);
        check_ready("st_ready", 1'b1, st_ready);

        for (int i = 0; i < 40; i++) begin
            r    = $random(seed);
            addr = pixel_cluster_pkg::addr_t'(1 + r[7:0] % 3);
            data = $random(seed);
            write_reg(addr, data, r[11:8]);
            be = r[15:12];
            bus_read(addr, be, got);
            check_reg($sformatf("reg%0d", addr), m_regs[addr] & byte_mask(be), got);
        end
        write_reg(pixel_cluster_pkg::REG_CONTROL, 32'hFFFF_FFFF, 4'hF);
        bus_read(pixel_cluster_pkg::REG_CONTROL, 4'hF, got);
        check_reg("control", '0, got);
        end_test("register access");

        // Random rules with a range wide enough that slot 0 takes every accepted pixel
        for (int f = 0; f < 4; f++) begin
            write_reg(pixel_cluster_pkg::REG_COMPARE_0, $random(seed), 4'hF);
            write_reg(pixel_cluster_pkg::REG_COMPARE_1, $random(seed), 4'hF);
            r = $random(seed);
            write_reg(pixel_cluster_pkg::REG_RANGE, {r[31:16], 16'hFFFF}, 4'hF);
            send_frame(1'b0);
            wait_irq();
            check_slots();
            clear_slots();
        end
        end_test("colour filtering");

        // Rule 0 wants red at or above 0x80 and rule 1 has no channel enabled
        write_reg(pixel_cluster_pkg::REG_COMPARE_0, 32'h0480_0000, 4'hF);
        write_reg(pixel_cluster_pkg::REG_COMPARE_1, $random(seed) & 32'h38FF_FFFF, 4'hF);
        for (int f = 0; f < 4; f++) begin
            r = $random(seed);
            write_reg(pixel_cluster_pkg::REG_RANGE, {r[31:16], 16'(2 + r[2:0])}, 4'hF);
            send_frame(1'b1);
            wait_irq();
            check_slots();
            clear_slots();
        end
        end_test("clustering");

        check_irq("irq_after_reset", 1'b0, irq_after_reset);
        send_frame(1'b1);
        wait_irq();
        check_slots();
        clear_slots();
        check_slots();
        send_frame(1'b1);
        wait_irq();
        check_slots();
        clear_slots();
        end_test("interrupt");

        send_frame(1'b1);
        wait_irq();
        send_frame(1'b1);
        check_irq("irq", 1'b1, irq);
        wait_cycles(IRQ_LATENCY);
        check_irq("irq", 1'b1, irq);
        check_slots();
        clear_slots();
        end_test("back-to-back frames");

        $display("Tests run: %0d, errors: %0d", test_num - 1, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
